// File: src.f
+incdir+src
src/vic_pkg.sv
src/wb_if.sv
src/bus_arbiter.sv
src/video_ram.sv
src/host_port.sv
src/raster_fetch.sv
src/palette_out.sv
src/vic_top.sv
dv/vic_assertions.sv
dv/tb_vic.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it; exit status is the result
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_vic -f src.f -o tb_vic
./obj_dir/tb_vic

// File: dv/tb_vic.sv
`include "vic_consts.svh"

// directed testbench for the video core
module tb_vic;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_CLKS = `VIC_H_TOTAL * `VIC_V_TOTAL * `VIC_DOT_DIV;
  localparam int N_ACTIVE   = `VIC_H_ACTIVE * `VIC_V_ACTIVE;
  localparam int ACK_LIMIT  = 64;            // clocks, enough to wait out a fetch pair
  localparam logic [3:0] SCR_BASE = 4'd2;    // screen at 0x0800
  localparam logic [2:0] CHR_BASE = 3'd3;    // glyphs at 0x1800

  logic               clk_col4x_pal = 1'b0;
  logic               rst_n;
  logic               host_cyc, host_stb, host_we;
  logic [14:0]        host_adr;
  vic_pkg::mem_data_t host_dat_w, host_dat_r;
  logic               host_ack, irq, dot_en, active, hsync, vsync;
  logic [5:0]         red, green, blue;

  vic_pkg::mem_data_t shadow [0:(1 << `VIC_MEM_AW)-1]; // every byte the host wrote
  vic_pkg::mem_addr_t wr_addrs [$];

  vic_top u_dut (.*);

  bind bus_arbiter vic_assertions u_arb_chk (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .fetch_cyc     (fetch.cyc),
    .fetch_stb     (fetch.stb),
    .fetch_ack     (fetch.ack),
    .host_cyc      (host.cyc),
    .host_stb      (host.stb),
    .host_ack      (host.ack),
    .ram_stb       (ram.stb),
    .ram_ack       (ram.ack)
  );

  always #50 clk_col4x_pal = ~clk_col4x_pal; // 100 ns period

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input vic_pkg::mem_data_t got, exp, input string what);
    if (got !== exp) abort_run($sformatf("Fail %0d ns: %s read %02h, expected %02h",
                                         $time, what, got, exp));
  endtask

  task automatic check_rgb(input vic_pkg::rgb_t got, exp, input string what);
    if (got !== exp) abort_run($sformatf("Fail %0d ns: %s rgb %0d/%0d/%0d, expected %0d/%0d/%0d",
      $time, what, got.red, got.green, got.blue, exp.red, exp.green, exp.blue));
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    if (got !== exp) abort_run($sformatf("Fail %0d ns: %s is %b, expected %b",
                                         $time, what, got, exp));
  endtask

  function automatic logic [14:0] reg_adr(input logic [2:0] idx);
    return {1'b1, 11'd0, idx};   // bit 14 selects the register file
  endfunction

  // bits each register keeps
  function automatic vic_pkg::mem_data_t field_mask(input logic [2:0] idx);
    case (idx)
      `VIC_REG_CTRL:                                  return 8'h01;
      `VIC_REG_BG, `VIC_REG_FG, `VIC_REG_SCREEN_BASE: return 8'h0f;
      `VIC_REG_RASTER_CMP:                            return 8'h3f;
      `VIC_REG_CHAR_BASE:                             return 8'h07;
      default:                                        return 8'h00;
    endcase
  endfunction

  // one wishbone classic cycle, stb held until ack
  task automatic host_cycle(input logic we, input logic [14:0] adr,
                            input vic_pkg::mem_data_t wdat, output vic_pkg::mem_data_t rdat);
    int n;
    @(posedge clk_col4x_pal);
    host_cyc   <= 1'b1;
    host_stb   <= 1'b1;
    host_we    <= we;
    host_adr   <= adr;
    host_dat_w <= wdat;
    n = 0;
    do begin
      @(negedge clk_col4x_pal);
      n++;
      if (n > ACK_LIMIT) abort_run($sformatf("host cycle to %h was never acknowledged", adr));
    end while (!host_ack);
    rdat = host_dat_r;
    @(posedge clk_col4x_pal);   // drop the cycle on the edge that saw ack
    host_cyc <= 1'b0;
    host_stb <= 1'b0;
    host_we  <= 1'b0;
  endtask

  task automatic host_write(input logic [14:0] adr, input vic_pkg::mem_data_t d);
    vic_pkg::mem_data_t unused;
    host_cycle(1'b1, adr, d, unused);
  endtask

  task automatic host_read(input logic [14:0] adr, output vic_pkg::mem_data_t d);
    host_cycle(1'b0, adr, 8'h00, d);
  endtask

  task automatic ram_write(input vic_pkg::mem_addr_t a, input vic_pkg::mem_data_t d);
    host_write({1'b0, a}, d);
    shadow[a] = d;
  endtask

  // returns just after vsync falls, ahead of line 0
  task automatic wait_frame_start();
    int   n;
    logic prev;
    @(negedge clk_col4x_pal);
    n = 0;
    do begin
      prev = vsync;
      @(negedge clk_col4x_pal);
      n++;
      if (n > 2 * FRAME_CLKS) abort_run("vsync did not fall within two frames");
    end while (!(prev && !vsync));
  endtask

  // one whole frame, every active pixel against the text mode rule
  task automatic check_frame(input logic en, input vic_pkg::colour_t bg, fg);
    int                 n_px, n, y, x;
    logic               prev, done;
    vic_pkg::mem_data_t code, glyph;
    vic_pkg::colour_t   c;
    wait_frame_start();
    n_px = 0;
    n    = 0;
    done = 1'b0;
    prev = vsync;
    while (!done) begin
      @(negedge clk_col4x_pal);
      n++;
      if (n > FRAME_CLKS + 64) abort_run("frame did not end in time");
      if (prev && !vsync) begin
        done = 1'b1;
      end else if (dot_en && active) begin
        if (n_px == N_ACTIVE) abort_run("more than 128 x 32 active pixels in a frame");
        y     = n_px / `VIC_H_ACTIVE;
        x     = n_px % `VIC_H_ACTIVE;
        code  = shadow[vic_pkg::mem_addr_t'(SCR_BASE * 1024 + (y / 8) * 16 + x / 8)];
        glyph = shadow[vic_pkg::mem_addr_t'(CHR_BASE * 2048 + code * 8 + y % 8)];
        c     = (en && glyph[7 - x % 8]) ? fg : bg;   // msb is the leftmost dot
        check_rgb(vic_pkg::rgb_t'({red, green, blue}), vic_pkg::palette_rgb[c],
                  $sformatf("pixel line %0d dot %0d", y, x));
        n_px++;
      end
      prev = vsync;
    end
    check_bit(n_px == N_ACTIVE, 1'b1, "full count of active pixels");
  endtask

  initial begin
    vic_pkg::mem_data_t d, rd;
    vic_pkg::mem_addr_t a;
    vic_pkg::colour_t   bg, fg;
    int                 i, n;
    void'($urandom(32'h1d16));
    rst_n      = 1'b0;
    host_cyc   = 1'b0;
    host_stb   = 1'b0;
    host_we    = 1'b0;
    host_adr   = '0;
    host_dat_w = '0;
    repeat (8) @(posedge clk_col4x_pal);
    rst_n <= 1'b1;
    @(negedge clk_col4x_pal);

    // reset values
    check_bit(irq, 1'b0, "irq after reset");
    check_bit(hsync, 1'b0, "hsync after reset");
    check_bit(vsync, 1'b0, "vsync after reset");
    for (i = 0; i < 8; i++) begin
      host_read(reg_adr(3'(i)), rd);
      check_byte(rd, 8'h00, $sformatf("register %0d after reset", i));
    end

    // random ram writes, then read all of them back
    for (i = 0; i < 48; i++) begin
      a = vic_pkg::mem_addr_t'($urandom);
      ram_write(a, vic_pkg::mem_data_t'($urandom));
      wr_addrs.push_back(a);
    end
    for (i = 0; i < wr_addrs.size(); i++) begin
      host_read({1'b0, wr_addrs[i]}, rd);
      check_byte(rd, shadow[wr_addrs[i]], $sformatf("ram %h", wr_addrs[i]));
    end

    // registers keep their field bits, 7 is empty, irq skipped here
    for (i = 0; i < 8; i++) begin
      if (i != `VIC_REG_IRQ) begin
        d = vic_pkg::mem_data_t'($urandom);
        host_write(reg_adr(3'(i)), d);
        host_read(reg_adr(3'(i)), rd);
        check_byte(rd, d & field_mask(3'(i)), $sformatf("register %0d", i));
      end
    end

    // text display, 4 rows of 16 codes and the full glyph set
    for (i = 0; i < 64; i++) ram_write(vic_pkg::mem_addr_t'(SCR_BASE * 1024 + i),
                                       vic_pkg::mem_data_t'($urandom));
    for (i = 0; i < 2048; i++) ram_write(vic_pkg::mem_addr_t'(CHR_BASE * 2048 + i),
                                         vic_pkg::mem_data_t'($urandom));
    bg = vic_pkg::colour_t'($urandom);
    fg = bg + vic_pkg::colour_t'(1 + $urandom_range(14, 0)); // never equal to bg
    host_write(reg_adr(`VIC_REG_SCREEN_BASE), {4'd0, SCR_BASE});
    host_write(reg_adr(`VIC_REG_CHAR_BASE), {5'd0, CHR_BASE});
    host_write(reg_adr(`VIC_REG_BG), {4'd0, bg});
    host_write(reg_adr(`VIC_REG_FG), {4'd0, fg});
    host_write(reg_adr(`VIC_REG_CTRL), 8'h01);
    check_frame(1'b1, bg, fg);

    // display off shows plain background
    bg = fg + vic_pkg::colour_t'(1 + $urandom_range(14, 0)); // glyph dots would show fg
    host_write(reg_adr(`VIC_REG_BG), {4'd0, bg});
    host_write(reg_adr(`VIC_REG_CTRL), 8'h00);
    check_frame(1'b0, bg, fg);

    // raster irq on line 10
    wait_frame_start();
    host_write(reg_adr(`VIC_REG_RASTER_CMP), 8'd10);
    host_write(reg_adr(`VIC_REG_IRQ), 8'h01);
    @(negedge clk_col4x_pal);
    check_bit(irq, 1'b0, "irq after clear");
    n = 0;
    while (!irq) begin
      @(negedge clk_col4x_pal);
      n++;
      if (n > FRAME_CLKS) abort_run("raster irq did not rise within a frame");
    end
    // line 10 is on screen now, so these compete with the fetcher
    for (i = 0; i < 16; i++) begin
      a = vic_pkg::mem_addr_t'($urandom);
      ram_write(a, vic_pkg::mem_data_t'($urandom));
      host_read({1'b0, a}, rd);
      check_byte(rd, shadow[a], $sformatf("ram %h during display", a));
    end
    check_bit(irq, 1'b1, "irq held until cleared");
    host_write(reg_adr(`VIC_REG_IRQ), 8'h01);
    @(negedge clk_col4x_pal);
    check_bit(irq, 1'b0, "irq after write of 1");
    host_read(reg_adr(`VIC_REG_IRQ), rd);
    check_byte(rd, 8'h00, "irq status after clear");

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: dv/vic_assertions.sv
// wishbone checks on the video ram arbiter
module vic_assertions (
  input logic clk_col4x_pal,
  input logic rst_n,
  input logic fetch_cyc,
  input logic fetch_stb,
  input logic fetch_ack,
  input logic host_cyc,
  input logic host_stb,
  input logic host_ack,
  input logic ram_stb,
  input logic ram_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  logic fetch_open;  // fetch was acked and has kept cyc up since
  logic host_open;   // same for the host

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      fetch_open <= 1'b0;
      host_open  <= 1'b0;
    end else begin
      fetch_open <= fetch_cyc && (fetch_ack || fetch_open);
      host_open  <= host_cyc && (host_ack || host_open);
    end
  end

  // a served master keeps the ram until it drops cyc, so only one owner at a time
  one_owner: assert property (@(posedge clk_col4x_pal) disable iff (!rst_n)
    !(fetch_open && host_ack) && !(host_open && fetch_ack))
    else $error("ack given to one master while the other still holds the ram");

  fetch_ack_ok: assert property (@(posedge clk_col4x_pal) disable iff (!rst_n)
    fetch_ack |-> fetch_cyc && fetch_stb) else $error("fetch ack outside a fetch cycle");

  host_ack_ok: assert property (@(posedge clk_col4x_pal) disable iff (!rst_n)
    host_ack |-> host_cyc && host_stb) else $error("host ack outside a host cycle");

  // ram strobe stays up until the ram answers it
  ram_stb_ok: assert property (@(posedge clk_col4x_pal) disable iff (!rst_n)
    ram_stb && !ram_ack |=> ram_stb) else $error("ram strobe dropped before its ack");

endmodule

// File: src/vic_top.sv
// video core top, host bus and video out as plain ports
module vic_top (
  input  logic        clk_col4x_pal,
  input  logic        rst_n,
  input  logic        host_cyc,
  input  logic        host_stb,
  input  logic        host_we,
  input  logic [14:0] host_adr,
  input  logic [7:0]  host_dat_w,
  output logic [7:0]  host_dat_r,
  output logic        host_ack,
  output logic        irq,
  output logic        dot_en,
  output logic        active,
  output logic        hsync,
  output logic        vsync,
  output logic [5:0]  red,
  output logic [5:0]  green,
  output logic [5:0]  blue
);

  wb_if fetch_bus ();
  wb_if host_bus ();
  wb_if ram_bus ();

  vic_pkg::vic_regs_t regs;
  logic               raster_hit;
  logic               rf_dot_en;    // raster side, one clock ahead of outputs
  vic_pkg::colour_t   rf_colour;
  logic               rf_active;
  logic               rf_hsync;
  logic               rf_vsync;

  bus_arbiter u_arb (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .fetch         (fetch_bus.slave),
    .host          (host_bus.slave),
    .ram           (ram_bus.master)
  );

  video_ram u_ram (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .bus           (ram_bus.slave)
  );

  host_port u_host (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .cyc           (host_cyc),
    .stb           (host_stb),
    .we            (host_we),
    .adr           (host_adr),
    .dat_w         (host_dat_w),
    .dat_r         (host_dat_r),
    .ack           (host_ack),
    .mem           (host_bus.master),
    .regs          (regs),
    .raster_hit    (raster_hit),
    .irq           (irq)
  );

  raster_fetch u_fetch (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .regs          (regs),
    .mem           (fetch_bus.master),
    .dot_en        (rf_dot_en),
    .colour        (rf_colour),
    .active        (rf_active),
    .hsync         (rf_hsync),
    .vsync         (rf_vsync),
    .raster_hit    (raster_hit)
  );

  palette_out u_pal (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .dot_en_in     (rf_dot_en),
    .colour        (rf_colour),
    .active_in     (rf_active),
    .hsync_in      (rf_hsync),
    .vsync_in      (rf_vsync),
    .dot_en        (dot_en),
    .active        (active),
    .hsync         (hsync),
    .vsync         (vsync),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

endmodule

// File: src/palette_out.sv
// colour index to rgb, registered together with the syncs
module palette_out (
  input  logic             clk_col4x_pal,
  input  logic             rst_n,
  input  logic             dot_en_in,
  input  vic_pkg::colour_t colour,
  input  logic             active_in,
  input  logic             hsync_in,
  input  logic             vsync_in,
  output logic             dot_en,
  output logic             active,
  output logic             hsync,
  output logic             vsync,
  output logic [5:0]       red,
  output logic [5:0]       green,
  output logic [5:0]       blue
);

  vic_pkg::rgb_t px;

  assign px = vic_pkg::palette_rgb[colour];

  // strobe and qualifiers delayed one clock to stay in step with rgb
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      dot_en <= 1'b0;
      active <= 1'b0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
    end else begin
      dot_en <= dot_en_in;
      active <= active_in;
      hsync  <= hsync_in;
      vsync  <= vsync_in;
    end
  end

  // black outside the visible area
  always_ff @(posedge clk_col4x_pal) begin
    red   <= active_in ? px.red   : 6'd0;
    green <= active_in ? px.green : 6'd0;
    blue  <= active_in ? px.blue  : 6'd0;
  end

endmodule

// File: src/raster_fetch.sv
`include "vic_consts.svh"

// raster timing, text mode fetch and pixel shifter
module raster_fetch (
  input  logic               clk_col4x_pal,
  input  logic               rst_n,
  input  vic_pkg::vic_regs_t regs,
  wb_if.master               mem,
  output logic               dot_en,
  output vic_pkg::colour_t   colour,
  output logic               active,
  output logic               hsync,
  output logic               vsync,
  output logic               raster_hit
);

  localparam int DIV_W = $clog2(`VIC_DOT_DIV);

  typedef enum logic [1:0] {
    F_IDLE,
    F_CODE,   // screen code read
    F_GLYPH   // glyph row read
  } fetch_state_t;

  logic [DIV_W-1:0]   div_q;
  logic [7:0]         h_q;          // dot in line
  logic [5:0]         v_q;          // line in frame
  logic [5:0]         v_next;
  logic               line_end;
  logic               cell_start;   // first dot of a character cell
  logic               in_area;      // current dot is visible

  logic [3:0]         tgt_col;      // cell the next fetch is for
  logic [5:0]         tgt_line;
  logic               tgt_ok;
  logic               fetch_start;

  fetch_state_t       state;
  logic [3:0]         fetch_col;
  logic [4:0]         fetch_line;
  vic_pkg::mem_data_t code_q;
  vic_pkg::mem_data_t next_glyph;   // row for the cell after this one
  vic_pkg::mem_data_t shift_q;
  logic               pix_bit;

  assign dot_en     = (div_q == DIV_W'(`VIC_DOT_DIV - 1));
  assign line_end   = (h_q == 8'(`VIC_H_TOTAL - 1));
  assign v_next     = (v_q == 6'(`VIC_V_TOTAL - 1)) ? 6'd0 : v_q + 6'd1;
  assign cell_start = (h_q[2:0] == 3'd0);
  assign in_area    = (h_q < 8'(`VIC_H_ACTIVE)) && (v_q < 6'(`VIC_V_ACTIVE));

  // dot divider and raster counters
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      div_q <= '0;
      h_q   <= '0;
      v_q   <= '0;
    end else begin
      div_q <= dot_en ? '0 : div_q + 1'b1;
      if (dot_en) begin
        h_q <= line_end ? 8'd0 : h_q + 8'd1;
        if (line_end) begin
          v_q <= v_next;
        end
      end
    end
  end

  // the cell ahead; last blank cell of a line fetches column 0 of the next
  always_comb begin
    if (h_q == 8'(`VIC_H_TOTAL - 8)) begin
      tgt_col  = 4'd0;
      tgt_line = v_next;
      tgt_ok   = v_next < 6'(`VIC_V_ACTIVE);
    end else begin
      tgt_col  = h_q[6:3] + 4'd1;
      tgt_line = v_q;
      tgt_ok   = (h_q < 8'(`VIC_H_ACTIVE - 8)) && (v_q < 6'(`VIC_V_ACTIVE));
    end
  end

  assign fetch_start = dot_en & cell_start & tgt_ok;

  // two reads per cell: screen code then glyph row
  assign mem.cyc   = (state != F_IDLE);
  assign mem.stb   = (state != F_IDLE);
  assign mem.we    = 1'b0;          // fetcher only reads
  assign mem.dat_w = '0;
  assign mem.adr   = (state == F_GLYPH) ?
                     {regs.char_base, code_q, fetch_line[2:0]} :
                     {regs.screen_base, 4'd0, fetch_line[4:3], fetch_col};

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      state <= F_IDLE;
    end else begin
      case (state)
        F_IDLE:  if (fetch_start) state <= F_CODE;
        F_CODE:  if (mem.ack) state <= F_GLYPH; // next cycle starts at once
        F_GLYPH: if (mem.ack) state <= F_IDLE;
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_col4x_pal) begin
    if (fetch_start && state == F_IDLE) begin
      fetch_col  <= tgt_col;
      fetch_line <= tgt_line[4:0];
    end
    if (state == F_CODE && mem.ack) code_q <= mem.dat_r;
    if (state == F_GLYPH && mem.ack) next_glyph <= mem.dat_r;
  end

  // msb first; a fresh row is picked up on the first dot of each cell
  assign pix_bit = cell_start ? next_glyph[7] : shift_q[7];

  always_ff @(posedge clk_col4x_pal) begin
    if (dot_en) begin
      shift_q <= cell_start ? {next_glyph[6:0], 1'b0} : {shift_q[6:0], 1'b0};
      colour  <= (regs.display_en && pix_bit) ? regs.fg : regs.bg;
    end
  end

  // pixel qualifiers, held for the dot period after the strobe
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      active     <= 1'b0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      raster_hit <= 1'b0;
    end else begin
      if (dot_en) begin
        active <= in_area;
        hsync  <= (h_q >= 8'(`VIC_HSYNC_START)) && (h_q < 8'(`VIC_HSYNC_END));
        vsync  <= (v_q >= 6'(`VIC_VSYNC_START)) && (v_q < 6'(`VIC_VSYNC_END));
      end
      raster_hit <= dot_en && line_end && (v_next == regs.raster_cmp); // one clock
    end
  end

endmodule

// File: src/host_port.sv
`include "vic_consts.svh"

// cpu side: register file, irq status, and forwarding to video ram
module host_port (
  input  logic                clk_col4x_pal,
  input  logic                rst_n,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [14:0]         adr,        // bit 14 selects registers
  input  vic_pkg::mem_data_t  dat_w,
  output vic_pkg::mem_data_t  dat_r,
  output logic                ack,
  wb_if.master                mem,
  output vic_pkg::vic_regs_t  regs,
  input  logic                raster_hit,
  output logic                irq
);

  logic               reg_sel;   // register cycle strobed
  logic               reg_req;   // first clock of it
  logic               reg_ack_q;
  vic_pkg::mem_data_t reg_rd_q;
  logic               irq_st;    // raster irq status

  assign reg_sel = cyc & stb & adr[14];
  assign reg_req = reg_sel & ~reg_ack_q;

  // memory cycles pass straight through to the arbiter
  assign mem.cyc   = cyc & ~adr[14];
  assign mem.stb   = stb & ~adr[14];
  assign mem.we    = we;
  assign mem.adr   = adr[13:0];
  assign mem.dat_w = dat_w;

  assign ack   = reg_ack_q | mem.ack;
  assign dat_r = reg_ack_q ? reg_rd_q : mem.dat_r;
  assign irq   = irq_st;

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      reg_ack_q <= 1'b0;
      regs      <= '0;    // display off, bg index 0
      irq_st    <= 1'b0;
    end else begin
      reg_ack_q <= reg_req;               // answer one cycle after stb
      if (reg_req && we) begin
        case (adr[2:0])
          `VIC_REG_CTRL:        regs.display_en  <= dat_w[0];
          `VIC_REG_BG:          regs.bg          <= dat_w[3:0];
          `VIC_REG_FG:          regs.fg          <= dat_w[3:0];
          `VIC_REG_RASTER_CMP:  regs.raster_cmp  <= dat_w[5:0];
          `VIC_REG_SCREEN_BASE: regs.screen_base <= dat_w[3:0];
          `VIC_REG_CHAR_BASE:   regs.char_base   <= dat_w[2:0];
          default: ;                      // irq handled below, 7 is empty
        endcase
      end
      // a new hit beats a clear in the same cycle
      if (raster_hit) begin
        irq_st <= 1'b1;
      end else if (reg_req && we && adr[2:0] == `VIC_REG_IRQ && dat_w[0]) begin
        irq_st <= 1'b0;                   // write 1 to clear
      end
    end
  end

  // read data captured with the strobe, presented with ack
  always_ff @(posedge clk_col4x_pal) begin
    if (reg_req) begin
      case (adr[2:0])
        `VIC_REG_CTRL:        reg_rd_q <= {7'd0, regs.display_en};
        `VIC_REG_BG:          reg_rd_q <= {4'd0, regs.bg};
        `VIC_REG_FG:          reg_rd_q <= {4'd0, regs.fg};
        `VIC_REG_RASTER_CMP:  reg_rd_q <= {2'd0, regs.raster_cmp};
        `VIC_REG_IRQ:         reg_rd_q <= {7'd0, irq_st};
        `VIC_REG_SCREEN_BASE: reg_rd_q <= {4'd0, regs.screen_base};
        `VIC_REG_CHAR_BASE:   reg_rd_q <= {5'd0, regs.char_base};
        default:              reg_rd_q <= '0;
      endcase
    end
  end

endmodule

// File: src/video_ram.sv
`include "vic_consts.svh"

// 16K x 8 single port ram behind a wishbone classic slave
module video_ram (
  input  logic clk_col4x_pal,
  input  logic rst_n,
  wb_if.slave  bus
);

  vic_pkg::mem_data_t mem [0:(1 << `VIC_MEM_AW)-1];
  vic_pkg::mem_data_t rd_q;   // registered read data
  logic               ack_q;
  logic               req;

  // a new request is one not already being acked
  assign req = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk_col4x_pal) begin
    if (req) begin
      if (bus.we) begin
        mem[bus.adr] <= bus.dat_w;
      end
      rd_q <= mem[bus.adr]; // old contents on a write, nobody looks
    end
  end

  // ack high for exactly one cycle per strobe
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = rd_q;

endmodule

// File: src/bus_arbiter.sv
// two masters onto one video ram port
// fetch wins when the bus is free, owner keeps it until cyc drops
module bus_arbiter (
  input  logic clk_col4x_pal,
  input  logic rst_n,
  wb_if.slave  fetch,
  wb_if.slave  host,
  wb_if.master ram
);

  logic busy;     // a cycle was running last clock
  logic owner;    // 1 = host, 0 = fetch
  logic hold;     // last owner still has cyc up
  logic sel_host; // who drives ram this clock

  // the owner keeps the bus while its cyc stays high, no preemption
  assign hold = busy & (owner ? host.cyc : fetch.cyc);

  // free bus is decided right away so a lone master loses no cycle
  always_comb begin
    if (hold) begin
      sel_host = owner;
    end else begin
      sel_host = ~fetch.cyc; // fetch first, else host (or nobody)
    end
  end

  // request mux
  assign ram.cyc   = sel_host ? host.cyc   : fetch.cyc;
  assign ram.stb   = sel_host ? host.stb   : fetch.stb;
  assign ram.we    = sel_host ? host.we    : fetch.we;
  assign ram.adr   = sel_host ? host.adr   : fetch.adr;
  assign ram.dat_w = sel_host ? host.dat_w : fetch.dat_w;

  // response goes to the owner only
  assign host.ack    = ram.ack & sel_host;
  assign fetch.ack   = ram.ack & ~sel_host;
  assign host.dat_r  = sel_host ? ram.dat_r : '0;
  assign fetch.dat_r = sel_host ? '0 : ram.dat_r;

  // grant register
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      owner <= 1'b0;
    end else begin
      busy  <= ram.cyc;  // grant taken while the selected cyc is up
      owner <= sel_host;
    end
  end

endmodule

// File: src/wb_if.sv
// wishbone classic link, 8 bit data and 14 bit address
interface wb_if;

  logic                cyc;
  logic                stb;
  logic                we;
  vic_pkg::mem_addr_t  adr;
  vic_pkg::mem_data_t  dat_w;  // master to slave
  vic_pkg::mem_data_t  dat_r;  // slave to master
  logic                ack;    // one cycle, ends the transfer

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

// File: src/vic_pkg.sv
`include "vic_consts.svh"

package vic_pkg;

  typedef logic [`VIC_MEM_AW-1:0] mem_addr_t; // video ram address
  typedef logic [7:0]             mem_data_t;
  typedef logic [3:0]             colour_t;   // palette index

  typedef struct packed {
    logic [5:0] red;
    logic [5:0] green;
    logic [5:0] blue;
  } rgb_t;

  // register file as seen by the video side
  typedef struct packed {
    logic       display_en;
    colour_t    bg;
    colour_t    fg;
    logic [5:0] raster_cmp;
    logic [3:0] screen_base; // address bits 13:10
    logic [2:0] char_base;   // address bits 13:11
  } vic_regs_t;

  // classic 16 colour set, 8 bit levels scaled down to 6 bits
  localparam rgb_t palette_rgb [0:15] = '{
    '{6'd0,  6'd0,  6'd0},   // black
    '{6'd63, 6'd63, 6'd63},  // white
    '{6'd26, 6'd13, 6'd10},  // red
    '{6'd28, 6'd41, 6'd44},  // cyan
    '{6'd27, 6'd15, 6'd33},  // purple
    '{6'd22, 6'd35, 6'd16},  // green
    '{6'd13, 6'd10, 6'd30},  // blue
    '{6'd46, 6'd49, 6'd27},  // yellow
    '{6'd27, 6'd19, 6'd9},   // orange
    '{6'd16, 6'd14, 6'd0},   // brown
    '{6'd38, 6'd25, 6'd22},  // light red
    '{6'd17, 6'd17, 6'd17},  // dark grey
    '{6'd27, 6'd27, 6'd27},  // grey
    '{6'd38, 6'd52, 6'd33},  // light green
    '{6'd27, 6'd23, 6'd45},  // light blue
    '{6'd37, 6'd37, 6'd37}   // light grey
  };

endpackage

// File: src/vic_consts.svh
`ifndef VIC_CONSTS_SVH
`define VIC_CONSTS_SVH

// raster geometry in dots and lines
`define VIC_H_TOTAL      160   // dots per line
`define VIC_H_ACTIVE     128   // 16 character columns
`define VIC_V_TOTAL      40    // lines per frame
`define VIC_V_ACTIVE     32    // 4 character rows
`define VIC_HSYNC_START  136
`define VIC_HSYNC_END    144
`define VIC_VSYNC_START  36
`define VIC_VSYNC_END    38

`define VIC_DOT_DIV      4     // clk_col4x_pal cycles per dot
`define VIC_MEM_AW       14    // 16K video ram

// host register map, selected by host_adr[2:0]
`define VIC_REG_CTRL        3'd0
`define VIC_REG_BG          3'd1
`define VIC_REG_FG          3'd2
`define VIC_REG_RASTER_CMP  3'd3
`define VIC_REG_IRQ         3'd4
`define VIC_REG_SCREEN_BASE 3'd5
`define VIC_REG_CHAR_BASE   3'd6

`endif
